// File: hw/spi_axil_regs.sv
// AXI4-Lite slave, one outstanding read and write; TX push needs wstrb[0], last needs wstrb[1]
module spi_axil_regs
  (
    input  logic                            i_Clk,
    input  logic                            i_Rst_L,

    // AXI4-Lite slave
    input  logic [spi_pkg::AXIL_ADDR_W-1:0] i_awaddr,
    input  logic                            i_awvalid,
    output logic                            o_awready,
    input  logic [31:0]                     i_wdata,
    input  logic [3:0]                      i_wstrb,
    input  logic                            i_wvalid,
    output logic                            o_wready,
    output logic [1:0]                      o_bresp,
    output logic                            o_bvalid,
    input  logic                            i_bready,
    input  logic [spi_pkg::AXIL_ADDR_W-1:0] i_araddr,
    input  logic                            i_arvalid,
    output logic                            o_arready,
    output logic [31:0]                     o_rdata,
    output logic [1:0]                      o_rresp,
    output logic                            o_rvalid,
    input  logic                            i_rready,

    // Byte path to sequencer
    output spi_pkg::spi_req_t               o_req,
    output logic                            o_req_valid,
    input  logic                            i_req_ready,
    input  logic                            i_rsp_dv,
    input  spi_pkg::spi_rsp_t               i_rsp,
    input  logic                            i_busy
  );
  import spi_pkg::*;

  logic        r_tx_full;   // Holding register occupied
  logic        r_rx_valid;
  logic        r_rx_ovr;
  spi_rsp_t    r_rx;        // Latest received byte
  logic        w_wr_ok;     // Raise write readies next cycle
  logic        w_wr_en;     // Write handshake
  logic        w_tx_wr;
  logic        w_rd_en;     // Read address handshake
  logic        w_rx_rd;
  logic [31:0] w_rd_mux;

  // TXDATA stalls here while full, other writes go through
  assign w_wr_ok = i_awvalid & i_wvalid & ~o_awready & ~o_bvalid &
                   ((i_awaddr != ADDR_TXDATA) | ~r_tx_full);
  assign w_wr_en = o_awready & i_awvalid & i_wvalid;
  assign w_tx_wr = w_wr_en & (i_awaddr == ADDR_TXDATA) & i_wstrb[0];
  assign w_rd_en = o_arready & i_arvalid;
  assign w_rx_rd = w_rd_en & (i_araddr == ADDR_RXDATA);

  assign o_req_valid = r_tx_full;
  assign o_bresp     = 2'b00;  // OKAY
  assign o_rresp     = 2'b00;

  //////////////////////////////
  // Write channel and TX hold

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
      r_tx_full <= 1'b0;
    end
    else
    begin
      o_awready <= w_wr_ok;  // Single cycle pulse, both together
      o_wready  <= w_wr_ok;
      if (w_wr_en)
        o_bvalid <= 1'b1;
      else if (i_bready)
        o_bvalid <= 1'b0;
      if (r_tx_full & i_req_ready)
        r_tx_full <= 1'b0;   // Sequencer took it
      if (w_tx_wr)
        r_tx_full <= 1'b1;
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (w_tx_wr)
    begin
      o_req.data <= i_wdata[7:0];
      o_req.last <= i_wdata[8] & i_wstrb[1];
    end
  end

  //////////////////////////////
  // Read channel and RX flags

  always_comb
  begin
    w_rd_mux = '0;  // Unmapped and TXDATA read as zero
    case (i_araddr)
      ADDR_STATUS: w_rd_mux[2:0] = {r_rx_ovr, r_rx_valid, i_busy | r_tx_full};
      ADDR_RXDATA: w_rd_mux[7:0] = r_rx.data;
      default:     w_rd_mux = '0;
    endcase
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_arready  <= 1'b0;
      o_rvalid   <= 1'b0;
      r_rx_valid <= 1'b0;
      r_rx_ovr   <= 1'b0;
    end
    else
    begin
      o_arready <= i_arvalid & ~o_arready & ~o_rvalid;
      if (w_rd_en)
        o_rvalid <= 1'b1;
      else if (i_rready)
        o_rvalid <= 1'b0;
      if (w_rx_rd)  // Clear on read
      begin
        r_rx_valid <= 1'b0;
        r_rx_ovr   <= 1'b0;
      end
      if (i_rsp_dv)  // New byte wins over a clear in the same cycle
      begin
        r_rx_valid <= 1'b1;
        r_rx_ovr   <= (r_rx_valid & ~w_rx_rd) | (r_rx_ovr & ~w_rx_rd);
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (w_rd_en)
      o_rdata <= w_rd_mux;
    if (i_rsp_dv)
      r_rx <= i_rsp;  // Overwrites unread data
  end

endmodule

// File: hw/spi_cs_ctrl.sv
// Single slave select; a byte without last keeps cs_n low until another byte arrives
module spi_cs_ctrl
  (
    input  logic              i_Clk,
    input  logic              i_Rst_L,

    // From register block
    input  spi_pkg::spi_req_t i_req,
    input  logic              i_req_valid,
    output logic              o_req_ready,

    // To and from bit engine
    output logic              o_tx_dv,
    output logic [7:0]        o_tx_byte,
    input  logic              i_tx_ready,
    input  logic              i_rx_dv,
    input  spi_pkg::spi_rsp_t i_rx_byte,

    // Received byte upward
    output logic              o_rsp_dv,
    output spi_pkg::spi_rsp_t o_rsp,

    output logic              o_spi_cs_n,
    output logic              o_busy       // Chip-select asserted
  );
  import spi_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_LEAD, ST_XFER, ST_WAIT, ST_TRAIL} state_t;

  state_t   r_state;
  spi_req_t r_req;  // Byte in flight
  logic [$clog2(CS_LEAD_CLKS+1)-1:0] r_cnt;  // Lead and trail gap
  logic     w_take;

  // Take a byte when idle, or between bytes once the engine is free
  assign o_req_ready = (r_state == ST_IDLE) | ((r_state == ST_XFER) & i_tx_ready);
  assign w_take      = i_req_valid & o_req_ready;
  assign o_tx_byte   = r_req.data;
  assign o_rsp_dv    = i_rx_dv;    // Engine result passes straight up
  assign o_rsp       = i_rx_byte;
  assign o_busy      = (r_state != ST_IDLE);

  always_ff @(posedge i_Clk)
  begin
    if (w_take)
      r_req <= i_req;
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state    <= ST_IDLE;
      r_cnt      <= '0;
      o_tx_dv    <= 1'b0;
      o_spi_cs_n <= 1'b1;
    end
    else
    begin
      o_tx_dv <= 1'b0;  // Pulse
      case (r_state)
        ST_IDLE:
          if (w_take)
          begin
            o_spi_cs_n <= 1'b0;
            r_cnt      <= '0;
            r_state    <= ST_LEAD;
          end
        ST_LEAD:  // tx_dv lands CS_LEAD_CLKS after cs_n falls
          if (r_cnt != CS_LEAD_CLKS-1)
            r_cnt <= r_cnt + 1'b1;
          else if (i_tx_ready)
          begin
            o_tx_dv <= 1'b1;
            r_state <= ST_WAIT;
          end
        ST_WAIT:
          if (i_rx_dv)
          begin
            r_cnt   <= '0;
            r_state <= r_req.last ? ST_TRAIL : ST_XFER;
          end
        ST_XFER:  // cs_n held low, next byte goes out as soon as it is written
          if (w_take)
          begin
            o_tx_dv <= 1'b1;
            r_state <= ST_WAIT;
          end
        ST_TRAIL:  // rx_dv cycle counts toward the hold
          if (r_cnt != CS_LEAD_CLKS-2)
            r_cnt <= r_cnt + 1'b1;
          else
          begin
            o_spi_cs_n <= 1'b1;
            r_state    <= ST_IDLE;
          end
        default:
          r_state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: hw/spi_ctrl_top.sv
// SPI master behind AXI4-Lite; mode and divider come from spi_pkg at build time
module spi_ctrl_top
  (
    input  logic                            i_Clk,
    input  logic                            i_Rst_L,

    // AXI4-Lite slave
    input  logic [spi_pkg::AXIL_ADDR_W-1:0] i_awaddr,
    input  logic                            i_awvalid,
    output logic                            o_awready,
    input  logic [31:0]                     i_wdata,
    input  logic [3:0]                      i_wstrb,
    input  logic                            i_wvalid,
    output logic                            o_wready,
    output logic [1:0]                      o_bresp,
    output logic                            o_bvalid,
    input  logic                            i_bready,
    input  logic [spi_pkg::AXIL_ADDR_W-1:0] i_araddr,
    input  logic                            i_arvalid,
    output logic                            o_arready,
    output logic [31:0]                     o_rdata,
    output logic [1:0]                      o_rresp,
    output logic                            o_rvalid,
    input  logic                            i_rready,

    // SPI pins
    output logic                            o_spi_clk,
    output logic                            o_spi_mosi,
    input  logic                            i_spi_miso,
    output logic                            o_spi_cs_n
  );
  import spi_pkg::*;

  spi_req_t   w_req;        // Holding register to sequencer
  logic       w_req_valid;
  logic       w_req_ready;
  spi_rsp_t   w_rsp;        // Sequencer to RX register
  logic       w_rsp_dv;
  logic       w_busy;
  logic       w_tx_dv;      // Sequencer to bit engine
  logic [7:0] w_tx_byte;
  logic       w_tx_ready;
  logic       w_rx_dv;
  spi_rsp_t   w_rx_byte;

  spi_axil_regs u_regs
  (
    .i_Clk       (i_Clk),
    .i_Rst_L     (i_Rst_L),
    .i_awaddr    (i_awaddr),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bresp     (o_bresp),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .i_araddr    (i_araddr),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .o_req       (w_req),
    .o_req_valid (w_req_valid),
    .i_req_ready (w_req_ready),
    .i_rsp_dv    (w_rsp_dv),
    .i_rsp       (w_rsp),
    .i_busy      (w_busy)
  );

  spi_cs_ctrl u_cs_ctrl
  (
    .i_Clk       (i_Clk),
    .i_Rst_L     (i_Rst_L),
    .i_req       (w_req),
    .i_req_valid (w_req_valid),
    .o_req_ready (w_req_ready),
    .o_tx_dv     (w_tx_dv),
    .o_tx_byte   (w_tx_byte),
    .i_tx_ready  (w_tx_ready),
    .i_rx_dv     (w_rx_dv),
    .i_rx_byte   (w_rx_byte),
    .o_rsp_dv    (w_rsp_dv),
    .o_rsp       (w_rsp),
    .o_spi_cs_n  (o_spi_cs_n),
    .o_busy      (w_busy)
  );

  // Package defaults for mode and divider
  spi_master u_master
  (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_dv    (w_tx_dv),
    .i_tx_byte  (w_tx_byte),
    .o_tx_ready (w_tx_ready),
    .o_rx_dv    (w_rx_dv),
    .o_rx_byte  (w_rx_byte),
    .o_spi_clk  (o_spi_clk),
    .i_spi_miso (i_spi_miso),
    .o_spi_mosi (o_spi_mosi)
  );

endmodule

// File: hw/spi_master.sv
// One byte per i_tx_dv, MSB first; no chip-select here and i_tx_dv only while o_tx_ready
module spi_master
  #(parameter int SPI_MODE          = spi_pkg::SPI_MODE_DEF,
    parameter int CLKS_PER_HALF_BIT = spi_pkg::CLKS_PER_HALF_BIT)
  (
    input  logic              i_Clk,
    input  logic              i_Rst_L,

    // Byte in
    input  logic              i_tx_dv,     // Single cycle start pulse
    input  logic [7:0]        i_tx_byte,   // Sampled only with i_tx_dv
    output logic              o_tx_ready,  // Idle, may take the next byte

    // Byte out
    output logic              o_rx_dv,     // One cycle, 16*CLKS_PER_HALF_BIT+2 after i_tx_dv
    output spi_pkg::spi_rsp_t o_rx_byte,

    // SPI pins
    output logic              o_spi_clk,
    input  logic              i_spi_miso,
    output logic              o_spi_mosi
  );

  logic w_cpol;  // SCLK idle level
  logic w_cpha;  // Data changes on leading edge when set

  logic [$clog2(2*CLKS_PER_HALF_BIT)-1:0] r_clk_cnt;  // Position within one SCLK period
  logic [4:0] r_edges;    // SCLK edges left in this byte
  logic       r_sclk;     // Internal clock, one cycle ahead of the pin
  logic       r_lead;     // Leading edge strobe
  logic       r_trail;    // Trailing edge strobe
  logic       r_tx_dv;    // Start pulse delayed by one
  logic [7:0] r_tx_shift;
  logic [7:0] r_rx_shift;

  logic w_shift_out;  // Present the next MOSI bit
  logic w_sample;     // Capture MISO
  logic w_last_edge;  // 16th edge just happened

  // Mode 0..3 decode
  assign w_cpol = (SPI_MODE == 2) || (SPI_MODE == 3);
  assign w_cpha = (SPI_MODE == 1) || (SPI_MODE == 3);

  // With CPHA=0 the first bit must sit on MOSI before any edge
  assign w_shift_out = (r_tx_dv & ~w_cpha) | (r_trail & ~w_cpha) | (r_lead & w_cpha);
  assign w_sample    = (r_lead & ~w_cpha) | (r_trail & w_cpha);
  assign w_last_edge = r_trail & (r_edges == 5'd0);

  //////////////////////////////
  // SCLK edge generator

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_tx_ready <= 1'b0;
      r_edges    <= '0;
      r_lead     <= 1'b0;
      r_trail    <= 1'b0;
      r_sclk     <= w_cpol;  // Idle level
      r_clk_cnt  <= '0;
    end
    else
    begin
      r_lead  <= 1'b0;  // Strobes last one cycle
      r_trail <= 1'b0;

      if (i_tx_dv)
      begin
        o_tx_ready <= 1'b0;
        r_edges    <= 5'd16;  // 8 bits, two edges each
        r_clk_cnt  <= '0;
      end
      else if (r_edges != 5'd0)
      begin
        o_tx_ready <= 1'b0;
        if (r_clk_cnt == 2*CLKS_PER_HALF_BIT-1)  // End of full period
        begin
          r_edges   <= r_edges - 5'd1;
          r_trail   <= 1'b1;
          r_clk_cnt <= '0;
          r_sclk    <= ~r_sclk;
        end
        else if (r_clk_cnt == CLKS_PER_HALF_BIT-1)  // Middle of period
        begin
          r_edges   <= r_edges - 5'd1;
          r_lead    <= 1'b1;
          r_clk_cnt <= r_clk_cnt + 1'b1;
          r_sclk    <= ~r_sclk;
        end
        else
        begin
          r_clk_cnt <= r_clk_cnt + 1'b1;
        end
      end
      else
      begin
        o_tx_ready <= 1'b1;  // Byte train finished
      end
    end
  end

  // Pin clock lags one cycle so it lines up with MOSI and the sample strobe
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_spi_clk <= w_cpol;
    else
      o_spi_clk <= r_sclk;
  end

  //////////////////////////////
  // MOSI side

  always_ff @(posedge i_Clk)
  begin
    if (i_tx_dv)
      r_tx_shift <= i_tx_byte;  // Caller may change its byte afterwards
    else if (w_shift_out)
      r_tx_shift <= {r_tx_shift[6:0], 1'b0};
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_tx_dv    <= 1'b0;
      o_spi_mosi <= 1'b0;
    end
    else
    begin
      r_tx_dv <= i_tx_dv;
      if (w_shift_out)
        o_spi_mosi <= r_tx_shift[7];  // MSB first
    end
  end

  //////////////////////////////
  // MISO side

  always_ff @(posedge i_Clk)
  begin
    if (w_sample)
      r_rx_shift <= {r_rx_shift[6:0], i_spi_miso};
    // CPHA=1 takes its 8th bit on this very edge
    if (w_last_edge)
      o_rx_byte.data <= w_cpha ? {r_rx_shift[6:0], i_spi_miso} : r_rx_shift;
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_rx_dv <= 1'b0;
    else
      o_rx_dv <= w_last_edge;  // Same timing in every mode
  end

endmodule

// File: hw/spi_pkg.sv
// Build-time constants only; SPI mode and SCLK divider cannot change while running
package spi_pkg;

  //////////////////////////////
  // SPI timing

  localparam int SPI_MODE_DEF      = 0;  // CPOL=0, CPHA=0
  localparam int CLKS_PER_HALF_BIT = 4;  // SCLK is i_Clk / 8, must be 2 or more
  localparam int CS_LEAD_CLKS      = 4;  // Setup before first byte and hold after last, 2 or more

  //////////////////////////////
  // AXI4-Lite register map

  localparam int AXIL_ADDR_W = 4;

  localparam logic [AXIL_ADDR_W-1:0] ADDR_TXDATA = 4'h0;  // W  [8] last, [7:0] byte
  localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 4'h4;  // R  [2] ovr, [1] rx_valid, [0] busy
  localparam logic [AXIL_ADDR_W-1:0] ADDR_RXDATA = 4'h8;  // R  [7:0] byte, clears flags

  //////////////////////////////
  // Internal byte transport

  // One byte headed for MOSI
  typedef struct packed {
    logic       last;  // Release chip-select after this byte
    logic [7:0] data;
  } spi_req_t;

  // One byte captured from MISO, qualified by a separate dv pulse
  typedef struct packed {
    logic [7:0] data;
  } spi_rsp_t;

endpackage

// File: spi_ctrl_top.f
hw/spi_pkg.sv
hw/spi_master.sv
hw/spi_cs_ctrl.sv
hw/spi_axil_regs.sv
hw/spi_ctrl_top.sv
verif/spi_ctrl_checker.sv
verif/spi_ctrl_tb.sv

// File: verif/spi_ctrl_checker.sv
// Passive monitor that assumes mode 0 pins and AXI inputs that change only on falling i_Clk
module spi_ctrl_checker
  (
    input  logic                            i_Clk,
    input  logic                            i_Rst_L,
    input  logic [spi_pkg::AXIL_ADDR_W-1:0] i_awaddr,
    input  logic                            i_awvalid,
    input  logic                            i_awready,
    input  logic [31:0]                     i_wdata,
    input  logic [3:0]                      i_wstrb,
    input  logic                            i_wvalid,
    input  logic                            i_wready,
    input  logic [1:0]                      i_bresp,
    input  logic                            i_bvalid,
    input  logic [spi_pkg::AXIL_ADDR_W-1:0] i_araddr,
    input  logic                            i_arvalid,
    input  logic                            i_arready,
    input  logic [31:0]                     i_rdata,
    input  logic [1:0]                      i_rresp,
    input  logic                            i_rvalid,
    input  logic                            i_rready,
    input  logic                            i_spi_clk,
    input  logic                            i_spi_mosi,
    input  logic                            i_spi_cs_n,
    input  logic [7:0]                      i_exp_rx,      // From the reference function
    output int                              o_errors,
    output int                              o_checks,
    output int                              o_mosi_bytes,
    output int                              o_cs_falls
  );
  timeunit 1ns;
  timeprecision 1ps;
  import spi_pkg::*;

  logic [7:0]             tx_q[$];    // Bytes accepted on TXDATA in write order
  logic [7:0]             shift;      // MOSI bits of the byte on the wire
  logic [7:0]             exp_byte;
  int                     nbits;
  logic                   prev_sclk;
  logic                   prev_cs_n;
  logic                   wr_hs;      // Write handshake seen on the last falling edge
  logic [AXIL_ADDR_W-1:0] rd_addr;    // Address of the read in flight

  initial
  begin
    o_errors     = 0;
    o_checks     = 0;
    o_mosi_bytes = 0;
    o_cs_falls   = 0;
    nbits        = 0;
    prev_sclk    = 1'b0;
    prev_cs_n    = 1'b1;
    wr_hs        = 1'b0;
    rd_addr      = '0;
  end

  // One compare that the testbench top also calls for register values
  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    o_checks = o_checks + 1;
    if (got !== exp)
    begin
      o_errors = o_errors + 1;
      $display("** Error %s exp 0x%0h got 0x%0h", name, exp, got);
    end
  endtask

  //////////////////////////////
  // AXI side

  always @(negedge i_Clk)
  begin
    if (i_Rst_L)
    begin
      if (wr_hs)
        compare_value("o_bvalid", 1, i_bvalid);  // Response one cycle after the accept
      if (i_awready || i_wready)
        compare_value("o_wready", i_awready, i_wready);  // Both readies pulse together
      if (i_bvalid)
        compare_value("o_bresp", 0, i_bresp);  // OKAY only
      if (i_rvalid)
        compare_value("o_rresp", 0, i_rresp);
      // Ready and valid both high here so the handshake lands on the next rising edge
      wr_hs = i_awready && i_awvalid && i_wvalid;
      if (wr_hs && i_awaddr == ADDR_TXDATA && i_wstrb[0])
        tx_q.push_back(i_wdata[7:0]);
      if (i_arready && i_arvalid)
        rd_addr = i_araddr;
      if (i_rvalid && i_rready && rd_addr == ADDR_RXDATA)
        compare_value("o_rdata", {24'h0, i_exp_rx}, i_rdata);  // Newest MISO byte
    end
  end

  //////////////////////////////
  // SPI side

  always @(negedge i_Clk)
  begin
    if (i_Rst_L)
    begin
      if (!i_spi_cs_n && prev_cs_n)
        o_cs_falls = o_cs_falls + 1;
      if (i_spi_cs_n && nbits != 0)
      begin
        o_errors = o_errors + 1;
        $display("Chip-select rose with only %0d bits of a byte shifted out", nbits);
        nbits = 0;
      end
      if (!i_spi_cs_n && i_spi_clk && !prev_sclk)  // Rising SCLK where the slave samples
      begin
        shift = {shift[6:0], i_spi_mosi};  // MSB first
        nbits = nbits + 1;
        if (nbits == 8)
        begin
          nbits        = 0;
          o_mosi_bytes = o_mosi_bytes + 1;
          if (tx_q.size() == 0)
          begin
            o_errors = o_errors + 1;
            $display("MOSI carried byte 0x%0h without a TXDATA write behind it", shift);
          end
          else
          begin
            exp_byte = tx_q.pop_front();
            compare_value("o_spi_mosi", {24'h0, exp_byte}, {24'h0, shift});
          end
        end
      end
    end
    prev_sclk = i_spi_clk;
    prev_cs_n = i_spi_cs_n;
  end

endmodule

// File: verif/spi_ctrl_tb.sv
// Slave model is mode 0 only; the run is capped by a cycle limit sized for 40 bytes
module spi_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import spi_pkg::*;

  localparam int NUM_XFERS      = 40;  // Bytes written over the whole run
  localparam int TIMEOUT_CYCLES = NUM_XFERS * (16*CLKS_PER_HALF_BIT + 40);

  logic                   i_Clk;
  logic                   i_Rst_L;
  logic [AXIL_ADDR_W-1:0] i_awaddr;
  logic                   i_awvalid;
  logic                   o_awready;
  logic [31:0]            i_wdata;
  logic [3:0]             i_wstrb;
  logic                   i_wvalid;
  logic                   o_wready;
  logic [1:0]             o_bresp;
  logic                   o_bvalid;
  logic                   i_bready;
  logic [AXIL_ADDR_W-1:0] i_araddr;
  logic                   i_arvalid;
  logic                   o_arready;
  logic [31:0]            o_rdata;
  logic [1:0]             o_rresp;
  logic                   o_rvalid;
  logic                   i_rready;
  logic                   o_spi_clk;
  logic                   o_spi_mosi;
  logic                   i_spi_miso;
  logic                   o_spi_cs_n;

  logic [7:0]  miso_pool [0:127];  // Slave reply bytes drawn right after seeding
  logic [7:0]  sent_q[$];          // Bytes the slave finished shifting out
  logic [7:0]  cur;                // Byte on MISO now
  logic [7:0]  exp_rx;
  logic        armed;
  logic        prev_sclk;
  logic [31:0] rnd;
  int          seed;
  int          pool_idx;
  int          bit_cnt;
  int          cycles;
  int          n_bytes;            // TXDATA writes issued
  int          cs_base;
  int          errors;
  int          checks;
  int          mosi_bytes;
  int          cs_falls;

  spi_ctrl_top DUT (.*);

  spi_ctrl_checker u_chk
  (
    .i_Clk        (i_Clk),
    .i_Rst_L      (i_Rst_L),
    .i_awaddr     (i_awaddr),
    .i_awvalid    (i_awvalid),
    .i_awready    (o_awready),
    .i_wdata      (i_wdata),
    .i_wstrb      (i_wstrb),
    .i_wvalid     (i_wvalid),
    .i_wready     (o_wready),
    .i_bresp      (o_bresp),
    .i_bvalid     (o_bvalid),
    .i_araddr     (i_araddr),
    .i_arvalid    (i_arvalid),
    .i_arready    (o_arready),
    .i_rdata      (o_rdata),
    .i_rresp      (o_rresp),
    .i_rvalid     (o_rvalid),
    .i_rready     (i_rready),
    .i_spi_clk    (o_spi_clk),
    .i_spi_mosi   (o_spi_mosi),
    .i_spi_cs_n   (o_spi_cs_n),
    .i_exp_rx     (exp_rx),
    .o_errors     (errors),
    .o_checks     (checks),
    .o_mosi_bytes (mosi_bytes),
    .o_cs_falls   (cs_falls)
  );

  initial
  begin
    i_Clk = 1'b0;
    forever #5 i_Clk = ~i_Clk;  // 100 MHz
  end

  //////////////////////////////
  // Reference and slave model

  // Byte the slave returned on transfer n counted from zero
  function automatic logic [7:0] expected_rx(input int n);
    logic [7:0] b;
    b = 8'h00;
    if (n >= 0 && n < sent_q.size())
      b = sent_q[n];
    return b;
  endfunction

  task automatic load_next_reply();
    cur        = miso_pool[pool_idx];
    pool_idx   = (pool_idx + 1) % 128;
    i_spi_miso = cur[7];  // MSB waits on the line for the first rising SCLK
  endtask

  // Mode 0 slave where MISO moves after SCLK falls and holds through the rise
  always @(negedge i_Clk)
  begin
    if (o_spi_cs_n)
    begin
      armed   = 1'b0;
      bit_cnt = 0;
    end
    else if (!armed)
    begin
      armed = 1'b1;
      load_next_reply();
    end
    else if (o_spi_clk && !prev_sclk)
    begin
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8)
      begin
        sent_q.push_back(cur);  // Master has all 8 bits now
        bit_cnt = 0;
      end
    end
    else if (!o_spi_clk && prev_sclk)
    begin
      if (bit_cnt == 0)
        load_next_reply();  // Dropped if chip-select rises first
      else
        i_spi_miso = cur[7-bit_cnt];
    end
    prev_sclk = o_spi_clk;
  end

  //////////////////////////////
  // AXI4-Lite master tasks

  task automatic write_reg(input logic [AXIL_ADDR_W-1:0] a, input logic [31:0] d);
    @(negedge i_Clk);
    i_awaddr  = a;
    i_wdata   = d;
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    @(negedge i_Clk);
    while (!o_awready)  // Held off while the TX hold is full
      @(negedge i_Clk);
    @(negedge i_Clk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
  endtask

  task automatic read_reg(input logic [AXIL_ADDR_W-1:0] a, output logic [31:0] d);
    @(negedge i_Clk);
    i_araddr  = a;
    i_arvalid = 1'b1;
    @(negedge i_Clk);
    while (!o_arready)
      @(negedge i_Clk);
    @(negedge i_Clk);
    i_arvalid = 1'b0;
    while (!o_rvalid)
      @(negedge i_Clk);
    d = o_rdata;  // rready is tied high so rvalid lasts one cycle
  endtask

  task automatic send_byte(input logic [7:0] b, input logic last);
    write_reg(ADDR_TXDATA, {23'h0, last, b});
    n_bytes = n_bytes + 1;
  endtask

  task automatic wait_status(input logic [31:0] mask, input logic [31:0] want);
    logic [31:0] d;
    read_reg(ADDR_STATUS, d);
    while ((d & mask) != want)
      read_reg(ADDR_STATUS, d);
  endtask

  task automatic check_status(input logic [31:0] exp);
    logic [31:0] d;
    read_reg(ADDR_STATUS, d);
    u_chk.compare_value("STATUS", exp, d);
  endtask

  task automatic read_rx();
    logic [31:0] d;
    @(negedge i_Clk);
    exp_rx = expected_rx(sent_q.size() - 1);  // Register keeps only the newest byte
    read_reg(ADDR_RXDATA, d);
  endtask

  //////////////////////////////
  // Test sequence

  initial
  begin
    seed = 32'haa6b;
    rnd  = $urandom(seed);
    for (int i = 0; i < 128; i++)
    begin
      rnd          = $urandom;
      miso_pool[i] = rnd[7:0];
    end
    i_Rst_L    = 1'b0;
    i_awaddr   = '0;
    i_awvalid  = 1'b0;
    i_wdata    = '0;
    i_wstrb    = 4'hf;
    i_wvalid   = 1'b0;
    i_bready   = 1'b1;
    i_araddr   = '0;
    i_arvalid  = 1'b0;
    i_rready   = 1'b1;
    i_spi_miso = 1'b0;
    exp_rx     = '0;
    armed      = 1'b0;
    prev_sclk  = 1'b0;
    pool_idx   = 0;
    bit_cnt    = 0;
    n_bytes    = 0;
    repeat (4) @(posedge i_Clk);
    @(negedge i_Clk);
    i_Rst_L = 1'b1;

    // Idle pins and empty status
    u_chk.compare_value("o_spi_cs_n", 1, o_spi_cs_n);
    u_chk.compare_value("o_spi_clk", (SPI_MODE_DEF >= 2) ? 1 : 0, o_spi_clk);
    check_status(0);

    // Lone byte under one chip-select pulse
    cs_base = cs_falls;
    send_byte(8'ha5, 1'b1);
    wait_status(32'h1, 32'h0);
    u_chk.compare_value("o_spi_cs_n falls", 1, cs_falls - cs_base);
    read_rx();
    check_status(0);  // rx_valid gone after the read

    // Four bytes under one chip-select
    cs_base = cs_falls;
    for (int i = 0; i < 4; i++)
    begin
      rnd = $urandom;
      send_byte(rnd[7:0], i == 3);
      wait_status(32'h2, 32'h2);
      read_rx();
    end
    wait_status(32'h1, 32'h0);
    u_chk.compare_value("o_spi_cs_n falls", 1, cs_falls - cs_base);

    // Engine busy with the first byte while two writes go back to back
    send_byte(8'h5a, 1'b1);
    send_byte(8'h3c, 1'b0);
    send_byte(8'hc3, 1'b1);  // Stalls until the hold register drains
    wait_status(32'h1, 32'h0);
    read_rx();

    // Two bytes with no read in between
    send_byte(8'h81, 1'b1);
    wait_status(32'h1, 32'h0);
    send_byte(8'h7e, 1'b1);
    wait_status(32'h1, 32'h0);
    check_status(32'h6);  // rx_valid and rx_overrun
    read_rx();
    check_status(0);

    // Random run
    for (int i = 0; i < 30; i++)
    begin
      rnd = $urandom;
      send_byte(rnd[7:0], rnd[8] || i == 29);  // Last byte closes chip-select
      wait_status(32'h2, 32'h2);
      read_rx();
    end
    wait_status(32'h1, 32'h0);
    check_status(0);
    u_chk.compare_value("MOSI byte count", n_bytes, mosi_bytes);
    u_chk.compare_value("MISO byte count", n_bytes, sent_q.size());

    $display("Checks %0d, errors %0d, bytes %0d", checks, errors, n_bytes);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // Cycle limit
  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge i_Clk);
      cycles = cycles + 1;
    end
    $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks %0d, errors %0d, bytes %0d", checks, errors, n_bytes);
    $display("Regression failed");
    $finish;
  end

endmodule
